//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // eight 32-bit columns per line
  localparam int unsigned COLUMN_BITS = 3;
  localparam int unsigned COLUMNS = 2 ** COLUMN_BITS;

  // a line moves as four 64-bit beats
  localparam int unsigned BEATS_PER_LINE = 4;

  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_op_e;

  // a request with wstrb all zero is a read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic dirty;
    logic valid;
  } line_flags_t;

  // one write into the line storage
  // the tag goes on its own port because its width follows the parameters
  typedef struct packed {
    logic [COLUMNS-1:0][3:0]  col_we;
    logic [COLUMNS-1:0][31:0] col_data;
    logic                     tag_we;
    line_flags_t              flags;
  } store_wr_t;

endpackage

`default_nettype wire

//--- logic/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store #(
  parameter int unsigned LINE_INDEX_BITS = 8,
  parameter int unsigned RAM_ADDR_BITS = 21
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [LINE_INDEX_BITS-1:0]             index,
  input  cache_pkg::store_wr_t                   wr,
  input  logic [RAM_ADDR_BITS+3-LINE_INDEX_BITS-cache_pkg::COLUMN_BITS-2-1:0] wr_tag,
  output logic [cache_pkg::COLUMNS-1:0][31:0]    col_data,
  output logic [RAM_ADDR_BITS+3-LINE_INDEX_BITS-cache_pkg::COLUMN_BITS-2-1:0] tag,
  output cache_pkg::line_flags_t                 flags
);

  localparam int unsigned TAG_BITS =
    RAM_ADDR_BITS + 3 - LINE_INDEX_BITS - cache_pkg::COLUMN_BITS - 2;
  localparam int unsigned LINES = 2 ** LINE_INDEX_BITS;

  logic [TAG_BITS-1:0] tag_mem [LINES];
  logic                dirty_mem [LINES];
  logic [LINES-1:0]    valid_bits;
  logic                dirty_q;
  logic                valid_q;

  // tag and dirty flag storage
  // a write at the read index shows up on the outputs right away
  always_ff @(posedge clk) begin
    if (wr.tag_we) begin
      tag_mem[index] <= wr_tag;
      dirty_mem[index] <= wr.flags.dirty;
      tag <= wr_tag;
      dirty_q <= wr.flags.dirty;
    end else begin
      tag <= tag_mem[index];
      dirty_q <= dirty_mem[index];
    end
  end

  // valid bits live in flops so all lines go invalid on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      valid_q <= 1'b0;
    end else begin
      if (wr.tag_we) begin
        valid_bits[index] <= wr.flags.valid;
      end
      valid_q <= wr.tag_we ? wr.flags.valid : valid_bits[index];
    end
  end

  assign flags.dirty = dirty_q;
  assign flags.valid = valid_q;

  // one byte-enabled array per column, all read at the same index
  for (genvar c = 0; c < cache_pkg::COLUMNS; c++) begin : g_col
    logic [3:0][7:0] mem [LINES];
    logic [3:0][7:0] rd_q;

    always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
        if (wr.col_we[c][b]) begin
          mem[index][b] <= wr.col_data[c][8*b +: 8];
          rd_q[b] <= wr.col_data[c][8*b +: 8];
        end else begin
          rd_q[b] <= mem[index][b];
        end
      end
    end

    assign col_data[c] = rd_q;
  end

  // a dirty line must also be valid or the eviction logic would skip it
  a_dirty_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr.tag_we |-> (wr.flags.valid || !wr.flags.dirty)
  );

endmodule

`default_nettype wire

//--- logic/cmd_interval_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_interval_timer #(
  parameter int unsigned CMD_INTERVAL_CYCLES = 13
) (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  output logic expired
);

  localparam int unsigned CNT_BITS = $clog2(CMD_INTERVAL_CYCLES + 1);

  logic [CNT_BITS-1:0] count;

  // starts at zero so the first command after reset may go at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_BITS'(CMD_INTERVAL_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign expired = (count == '0);

  // the controller only strobes a command once the gap has run out
  a_load_when_expired: assert property (
    @(posedge clk) disable iff (!rst_n)
    load |-> expired
  );

endmodule

`default_nettype wire

//--- logic/burst_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module burst_ctrl_fsm #(
  parameter int unsigned LINE_INDEX_BITS = 8,
  parameter int unsigned RAM_ADDR_BITS = 21
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // processor side
  input  logic                                   req_valid,
  input  cache_pkg::cpu_req_t                    req,
  output logic                                   req_ready,
  output logic                                   rsp_valid,
  output cache_pkg::cpu_rsp_t                    rsp,

  // burst RAM side
  output logic                                   br_cmd_en,
  output cache_pkg::br_op_e                      br_op,
  output logic [RAM_ADDR_BITS-1:0]               br_addr,
  output logic [63:0]                            br_wr_data,
  input  logic [63:0]                            br_rd_data,
  input  logic                                   br_rd_data_valid,

  // line store
  output logic [LINE_INDEX_BITS-1:0]             index,
  output cache_pkg::store_wr_t                   wr,
  output logic [RAM_ADDR_BITS+3-LINE_INDEX_BITS-cache_pkg::COLUMN_BITS-2-1:0] wr_tag,
  input  logic [cache_pkg::COLUMNS-1:0][31:0]    col_data,
  input  logic [RAM_ADDR_BITS+3-LINE_INDEX_BITS-cache_pkg::COLUMN_BITS-2-1:0] tag,
  input  cache_pkg::line_flags_t                 flags,

  // command interval timer
  output logic                                   load,
  input  logic                                   expired
);

  localparam int unsigned TAG_BITS =
    RAM_ADDR_BITS + 3 - LINE_INDEX_BITS - cache_pkg::COLUMN_BITS - 2;
  localparam int unsigned OFFSET_BITS = cache_pkg::COLUMN_BITS + 2;
  localparam int unsigned BEAT_BITS = $clog2(cache_pkg::BEATS_PER_LINE);
  localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(cache_pkg::BEATS_PER_LINE - 1);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    EVICT_WAIT,
    FILL_WAIT,
    FILL,
    TAG_UPDATE
  } state_e;

  state_e                          state;
  cache_pkg::cpu_req_t             req_q;
  logic [63:0]                     beat_q;
  logic [BEAT_BITS-1:0]            beat_cnt;
  logic [BEAT_BITS-1:0]            out_beat;

  logic [cache_pkg::COLUMN_BITS-1:0] col_sel;
  logic [LINE_INDEX_BITS-1:0]      req_index;
  logic [TAG_BITS-1:0]             req_tag;
  logic                            hit;
  logic                            victim_dirty;
  logic                            is_write;
  logic                            issue_evict;
  logic                            issue_fill;

  // |tag|index|col|00| split of the byte address
  assign col_sel   = req_q.addr[OFFSET_BITS-1:2];
  assign req_index = req_q.addr[OFFSET_BITS +: LINE_INDEX_BITS];
  assign req_tag   = req_q.addr[OFFSET_BITS+LINE_INDEX_BITS +: TAG_BITS];

  assign hit          = flags.valid && (tag == req_tag);
  assign victim_dirty = flags.valid && flags.dirty;
  assign is_write     = (req_q.wstrb != '0);

  // commands only leave while the spacing timer reads zero
  assign issue_evict = (state == LOOKUP) && !hit && victim_dirty && expired;
  assign issue_fill  = ((state == LOOKUP) && !hit && !victim_dirty && expired) ||
                       ((state == EVICT_WAIT) && expired);

  assign br_cmd_en = issue_evict || issue_fill;
  assign load      = br_cmd_en;
  assign br_op     = issue_evict ? cache_pkg::BR_WRITE : cache_pkg::BR_READ;
  assign br_addr   = issue_evict ? {tag, req_index, {BEAT_BITS{1'b0}}}
                                 : {req_tag, req_index, {BEAT_BITS{1'b0}}};

  // beat 0 goes out with the write strobe, beats 1 to 3 follow in EVICT
  assign out_beat   = (state == EVICT) ? beat_cnt : '0;
  assign br_wr_data = {col_data[{out_beat, 1'b1}], col_data[{out_beat, 1'b0}]};

  assign req_ready = (state == IDLE);
  assign rsp_valid = (state == LOOKUP) && hit;
  assign rsp.rdata = col_data[col_sel];

  // the incoming index is presented while idle so LOOKUP sees its line
  assign index  = (state == IDLE) ? req.addr[OFFSET_BITS +: LINE_INDEX_BITS] : req_index;
  assign wr_tag = req_tag;

  always_comb begin
    wr = '0;
    for (int i = 0; i < cache_pkg::COLUMNS; i++) begin
      if (state == FILL) begin
        wr.col_data[i] = (i % 2 == 1) ? beat_q[63:32] : beat_q[31:0];
      end else begin
        wr.col_data[i] = req_q.wdata;
      end
    end

    // write hit merges the strobed bytes and marks the line dirty
    if ((state == LOOKUP) && hit && is_write) begin
      wr.col_we[col_sel] = req_q.wstrb;
      wr.tag_we = 1'b1;
      wr.flags.dirty = 1'b1;
      wr.flags.valid = 1'b1;
    end

    // each fill beat lands in one pair of columns
    if (state == FILL) begin
      wr.col_we[{beat_cnt, 1'b0}] = 4'hf;
      wr.col_we[{beat_cnt, 1'b1}] = 4'hf;
    end

    if (state == TAG_UPDATE) begin
      wr.tag_we = 1'b1;
      wr.flags.dirty = 1'b0;
      wr.flags.valid = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      beat_cnt <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          if (req_valid) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state <= IDLE;
          end else if (issue_evict) begin
            beat_cnt <= BEAT_BITS'(1);
            state <= EVICT;
          end else if (issue_fill) begin
            state <= FILL_WAIT;
          end
        end
        EVICT: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) begin
            state <= EVICT_WAIT;
          end
        end
        EVICT_WAIT: begin
          if (expired) begin
            state <= FILL_WAIT;
          end
        end
        FILL_WAIT: begin
          if (br_rd_data_valid) begin
            beat_cnt <= '0;
            state <= FILL;
          end
        end
        FILL: begin
          // RAM delivers the remaining beats on consecutive cycles
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) begin
            state <= TAG_UPDATE;
          end
        end
        TAG_UPDATE: begin
          state <= LOOKUP;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (br_rd_data_valid) begin
      beat_q <= br_rd_data;
    end
  end

  a_cmd_when_expired: assert property (
    @(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> expired
  );

  a_rsp_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_valid |=> !rsp_valid
  );

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
  parameter int unsigned LINE_INDEX_BITS = 8,
  parameter int unsigned RAM_ADDR_BITS = 21,
  parameter int unsigned CMD_INTERVAL_CYCLES = 13
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid,
  input  cache_pkg::cpu_req_t      req,
  output logic                     req_ready,
  output logic                     rsp_valid,
  output cache_pkg::cpu_rsp_t      rsp,
  output logic                     br_cmd_en,
  output cache_pkg::br_op_e        br_op,
  output logic [RAM_ADDR_BITS-1:0] br_addr,
  output logic [63:0]              br_wr_data,
  input  logic [63:0]              br_rd_data,
  input  logic                     br_rd_data_valid
);

  localparam int unsigned TAG_BITS =
    RAM_ADDR_BITS + 3 - LINE_INDEX_BITS - cache_pkg::COLUMN_BITS - 2;

  logic [LINE_INDEX_BITS-1:0]                index;
  cache_pkg::store_wr_t                      store_wr;
  logic [TAG_BITS-1:0]                       wr_tag;
  logic [cache_pkg::COLUMNS-1:0][31:0]       col_data;
  logic [TAG_BITS-1:0]                       tag;
  cache_pkg::line_flags_t                    flags;
  logic                                      load;
  logic                                      expired;

  line_store #(
    .LINE_INDEX_BITS (LINE_INDEX_BITS),
    .RAM_ADDR_BITS   (RAM_ADDR_BITS)
  ) u_line_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .index    (index),
    .wr       (store_wr),
    .wr_tag   (wr_tag),
    .col_data (col_data),
    .tag      (tag),
    .flags    (flags)
  );

  cmd_interval_timer #(
    .CMD_INTERVAL_CYCLES (CMD_INTERVAL_CYCLES)
  ) u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .expired (expired)
  );

  burst_ctrl_fsm #(
    .LINE_INDEX_BITS (LINE_INDEX_BITS),
    .RAM_ADDR_BITS   (RAM_ADDR_BITS)
  ) u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid        (req_valid),
    .req              (req),
    .req_ready        (req_ready),
    .rsp_valid        (rsp_valid),
    .rsp              (rsp),
    .br_cmd_en        (br_cmd_en),
    .br_op            (br_op),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid),
    .index            (index),
    .wr               (store_wr),
    .wr_tag           (wr_tag),
    .col_data         (col_data),
    .tag              (tag),
    .flags            (flags),
    .load             (load),
    .expired          (expired)
  );

endmodule

`default_nettype wire

//--- testbench/burst_ram_model.sv
`timescale 1ns/100ps
`default_nettype none

module burst_ram_model #(
  parameter int unsigned RAM_ADDR_BITS = 12,
  parameter int unsigned CMD_INTERVAL_CYCLES = 13,
  parameter int unsigned READ_LATENCY = 5
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_en,
  input  cache_pkg::br_op_e        op,
  input  logic [RAM_ADDR_BITS-1:0] addr,
  input  logic [63:0]              wr_data,
  output logic [63:0]              rd_data,
  output logic                     rd_data_valid,
  output int unsigned              write_cmds,
  output int unsigned              read_cmds,
  output int unsigned              spacing_errors
);

  localparam int unsigned BEATS = cache_pkg::BEATS_PER_LINE;

  logic [63:0]              mem [2**RAM_ADDR_BITS];
  logic [RAM_ADDR_BITS-1:0] wr_addr;
  logic [RAM_ADDR_BITS-1:0] rd_addr;
  int unsigned              wr_left;
  int unsigned              rd_timer;
  int unsigned              since_cmd;

  // word n starts with 2n in its low half and 2n+1 in its high half
  initial begin
    spacing_errors = 0;
    for (int i = 0; i < 2**RAM_ADDR_BITS; i++) begin
      mem[i] = {32'(2 * i + 1), 32'(2 * i)};
    end
  end

  // beat 0 arrives with the write command, beats 1 to 3 on the next cycles
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_left <= 0;
      wr_addr <= '0;
    end else if (cmd_en && op == cache_pkg::BR_WRITE) begin
      mem[addr] <= wr_data;
      wr_addr <= addr + 1'b1;
      wr_left <= BEATS - 1;
    end else if (wr_left != 0) begin
      mem[wr_addr] <= wr_data;
      wr_addr <= wr_addr + 1'b1;
      wr_left <= wr_left - 1;
    end
  end

  // read beats leave on consecutive cycles once the latency has passed
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_timer <= 0;
      rd_addr <= '0;
      rd_data <= '0;
      rd_data_valid <= 1'b0;
      write_cmds <= 0;
      read_cmds <= 0;
      since_cmd <= CMD_INTERVAL_CYCLES + 1;
    end else begin
      rd_data_valid <= 1'b0;
      if (since_cmd <= CMD_INTERVAL_CYCLES) begin
        since_cmd <= since_cmd + 1;
      end
      if (rd_timer != 0) begin
        rd_timer <= rd_timer - 1;
        if (rd_timer <= BEATS) begin
          rd_data_valid <= 1'b1;
          rd_data <= mem[rd_addr];
          rd_addr <= rd_addr + 1'b1;
        end
      end
      if (cmd_en) begin
        since_cmd <= 1;
        if (op == cache_pkg::BR_WRITE) begin
          write_cmds <= write_cmds + 1;
        end else begin
          read_cmds <= read_cmds + 1;
          rd_timer <= READ_LATENCY + BEATS - 1;
          rd_addr <= addr;
        end
      end
    end
  end

  a_cmd_spacing: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_en |-> (since_cmd > CMD_INTERVAL_CYCLES)
  ) else begin
    spacing_errors++;
    $display("RAM command at %0t came only %0d cycles after the previous one",
             $time, $sampled(since_cmd));
  end

  task automatic read_word(input logic [RAM_ADDR_BITS-1:0] a, output logic [63:0] d);
    d = mem[a];
  endtask

endmodule

`default_nettype wire

//--- testbench/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

  localparam int unsigned LINE_INDEX_BITS = 4;
  localparam int unsigned RAM_ADDR_BITS = 12;
  localparam int unsigned CMD_INTERVAL_CYCLES = 13;
  localparam int unsigned OFFSET_BITS = cache_pkg::COLUMN_BITS + 2;
  localparam int unsigned TAG_BITS = RAM_ADDR_BITS + 3 - LINE_INDEX_BITS - OFFSET_BITS;
  localparam int unsigned LINES = 2 ** LINE_INDEX_BITS;
  localparam int unsigned NUM_OPS = 315;
  localparam int unsigned MARGIN_CYCLES = 200;

  logic                     clk;
  logic                     rst_n;
  logic                     req_valid;
  cache_pkg::cpu_req_t      req;
  logic                     req_ready;
  logic                     rsp_valid;
  cache_pkg::cpu_rsp_t      rsp;
  logic                     br_cmd_en;
  cache_pkg::br_op_e        br_op;
  logic [RAM_ADDR_BITS-1:0] br_addr;
  logic [63:0]              br_wr_data;
  logic [63:0]              br_rd_data;
  logic                     br_rd_data_valid;
  int unsigned              ram_write_cmds;
  int unsigned              ram_read_cmds;
  int unsigned              ram_spacing_errors;

  // shadow memory and a copy of the tag state are both advanced at acceptance
  logic [31:0]              shadow [int unsigned];
  logic [TAG_BITS-1:0]      line_tag [LINES];
  logic                     line_valid [LINES];
  logic                     line_dirty [LINES];
  logic                     pend_busy;
  logic                     pend_write;
  logic [31:0]              pend_addr;
  logic [31:0]              pend_exp;
  int unsigned              acc_count;
  int unsigned              rsp_count;
  int unsigned              exp_evictions;
  int unsigned              exp_fills;
  int                       errors;
  int                       err_mark;
  int                       test_num;
  int                       pass_count;
  int                       fail_count;

  logic                       accept;
  logic [LINE_INDEX_BITS-1:0] acc_index;
  logic [TAG_BITS-1:0]        acc_tag;
  logic                       acc_hit;
  logic                       acc_write;

  assign accept    = req_valid && req_ready;
  assign acc_index = req.addr[OFFSET_BITS +: LINE_INDEX_BITS];
  assign acc_tag   = req.addr[OFFSET_BITS+LINE_INDEX_BITS +: TAG_BITS];
  assign acc_hit   = line_valid[acc_index] && (line_tag[acc_index] == acc_tag);
  assign acc_write = (req.wstrb != 4'h0);

  cache_top #(
    .LINE_INDEX_BITS     (LINE_INDEX_BITS),
    .RAM_ADDR_BITS       (RAM_ADDR_BITS),
    .CMD_INTERVAL_CYCLES (CMD_INTERVAL_CYCLES)
  ) DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid        (req_valid),
    .req              (req),
    .req_ready        (req_ready),
    .rsp_valid        (rsp_valid),
    .rsp              (rsp),
    .br_cmd_en        (br_cmd_en),
    .br_op            (br_op),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model #(
    .RAM_ADDR_BITS       (RAM_ADDR_BITS),
    .CMD_INTERVAL_CYCLES (CMD_INTERVAL_CYCLES)
  ) u_ram (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_en         (br_cmd_en),
    .op             (br_op),
    .addr           (br_addr),
    .wr_data        (br_wr_data),
    .rd_data        (br_rd_data),
    .rd_data_valid  (br_rd_data_valid),
    .write_cmds     (ram_write_cmds),
    .read_cmds      (ram_read_cmds),
    .spacing_errors (ram_spacing_errors)
  );

  // RAM word n starts as {2n+1, 2n}, so the 32-bit word at byte address a starts as a / 4
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    int unsigned w;
    w = addr[RAM_ADDR_BITS+2:2];
    if (shadow.exists(w)) begin
      return shadow[w];
    end
    return 32'(w);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0] wstrb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] make_addr(input int unsigned tag, input int unsigned index,
                                            input int unsigned col);
    return 32'((tag << (LINE_INDEX_BITS + OFFSET_BITS)) | (index << OFFSET_BITS) | (col << 2));
  endfunction

  function automatic int total_errors();
    return errors + int'(ram_spacing_errors);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_busy <= 1'b0;
      pend_write <= 1'b0;
      pend_addr <= '0;
      pend_exp <= '0;
      acc_count <= 0;
      rsp_count <= 0;
      exp_evictions <= 0;
      exp_fills <= 0;
      for (int i = 0; i < LINES; i++) begin
        line_tag[i] <= '0;
        line_valid[i] <= 1'b0;
        line_dirty[i] <= 1'b0;
      end
    end else begin
      if (accept) begin
        pend_busy <= 1'b1;
        pend_write <= acc_write;
        pend_addr <= req.addr;
        pend_exp <= expected_word(req.addr);
        acc_count <= acc_count + 1;
        // every miss fetches the new line with one read command
        if (!acc_hit) begin
          exp_fills <= exp_fills + 1;
        end
        // a miss on a dirty line has to write the old line back
        if (!acc_hit && line_valid[acc_index] && line_dirty[acc_index]) begin
          exp_evictions <= exp_evictions + 1;
        end
        line_tag[acc_index] <= acc_tag;
        line_valid[acc_index] <= 1'b1;
        line_dirty[acc_index] <= (acc_hit && line_dirty[acc_index]) || acc_write;
        if (acc_write) begin
          shadow[req.addr[RAM_ADDR_BITS+2:2]] =
            merge_bytes(expected_word(req.addr), req.wdata, req.wstrb);
        end
      end
      if (rsp_valid) begin
        pend_busy <= 1'b0;
        rsp_count <= rsp_count + 1;
      end
    end
  end

  a_read_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rsp_valid && !pend_write) |-> (rsp.rdata == pend_exp)
  ) else begin
    errors++;
    $display("Error at %0t: read of %h returned %h, expected %h",
             $time, $sampled(pend_addr), $sampled(rsp.rdata), $sampled(pend_exp));
  end

  a_hit_next_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (accept && acc_hit) |=> rsp_valid
  ) else begin
    errors++;
    $display("hit to %h at %0t was not answered in the next cycle", pend_addr, $time);
  end

  a_one_rsp_per_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_valid |-> pend_busy
  ) else begin
    errors++;
    $display("response at %0t arrived with no request outstanding", $time);
  end

  // ready only while no request is outstanding, and high straight after reset
  a_ready_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_ready == !pend_busy
  ) else begin
    errors++;
    $display("req_ready at %0t did not follow the outstanding request", $time);
  end

  // returns one cycle after acceptance with req_valid still high
  task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] wstrb);
    req_valid = 1'b1;
    req.addr = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_idle();
    @(negedge clk);
    while (pend_busy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic do_read(input logic [31:0] addr);
    issue(addr, 32'h0, 4'h0);
    req_valid = 1'b0;
    wait_for_idle();
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb);
    issue(addr, wdata, wstrb);
    req_valid = 1'b0;
    wait_for_idle();
  endtask

  // the written line must have reached the RAM through the eviction
  task automatic check_ram_line(input logic [31:0] addr);
    logic [RAM_ADDR_BITS-1:0] base;
    logic [31:0]              col_addr;
    logic [63:0]              got;
    logic [63:0]              exp;
    base = {addr[RAM_ADDR_BITS+2:OFFSET_BITS], 2'b00};
    for (int k = 0; k < cache_pkg::BEATS_PER_LINE; k++) begin
      col_addr = {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}} + 32'(8 * k);
      u_ram.read_word(base + RAM_ADDR_BITS'(k), got);
      exp = {expected_word(col_addr + 32'd4), expected_word(col_addr)};
      assert (got == exp) else begin
        errors++;
        $display("Error at %0t: RAM word %h holds %h, expected %h", $time,
                 base + RAM_ADDR_BITS'(k), got, exp);
      end
    end
  endtask

  task automatic check_cmd_counts();
    assert (ram_write_cmds == exp_evictions) else begin
      errors++;
      $display("Error at %0t: %0d write commands seen, %0d evictions expected",
               $time, ram_write_cmds, exp_evictions);
    end
    assert (ram_read_cmds == exp_fills) else begin
      errors++;
      $display("Error at %0t: %0d read commands seen, %0d line fills expected",
               $time, ram_read_cmds, exp_fills);
    end
  endtask

  task automatic report_test(input string name);
    int now;
    now = total_errors();
    test_num++;
    if (now == err_mark) begin
      pass_count++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d errors", test_num, name, now - err_mark);
    end
    err_mark = now;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (NUM_OPS * 60 + MARGIN_CYCLES) @(posedge clk);
    $display("watchdog expired at %0t with requests still running", $time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] addr_r;
    void'($urandom(79541));
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    errors = 0;
    err_mark = 0;
    test_num = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    do_read(make_addr(0, 0, 1));
    do_read(make_addr(0, 0, 6));
    report_test("read miss then hit");

    do_write(make_addr(0, 0, 6), 32'ha5c3_9e17, 4'b0101);
    do_read(make_addr(0, 0, 6));
    report_test("partial write hit");

    addr_a = make_addr(0, 2, 3);
    addr_b = make_addr(1, 2, 0);
    do_write(addr_a, 32'h1234_5678, 4'hf);
    do_read(addr_b);
    check_ram_line(addr_a);
    do_read(addr_a);
    report_test("dirty conflict eviction");

    do_read(make_addr(2, 5, 4));
    do_read(make_addr(3, 5, 7));
    check_cmd_counts();
    report_test("clean conflict miss");

    // req_valid stays high from one request to the next
    issue(make_addr(0, 7, 0), 32'h0, 4'h0);
    issue(make_addr(1, 7, 2), 32'hdead_beef, 4'b1100);
    issue(make_addr(2, 7, 5), 32'h0, 4'h0);
    issue(make_addr(2, 7, 1), 32'h0, 4'h0);
    issue(make_addr(3, 7, 3), 32'h0bad_f00d, 4'hf);
    issue(make_addr(0, 7, 0), 32'h0, 4'h0);
    req_valid = 1'b0;
    wait_for_idle();
    assert (rsp_count == acc_count) else begin
      errors++;
      $display("Error at %0t: %0d responses for %0d requests", $time, rsp_count, acc_count);
    end
    check_cmd_counts();
    report_test("back-to-back requests");

    for (int i = 0; i < 300; i++) begin
      addr_r = make_addr($urandom_range(3, 0), $urandom_range(LINES - 1, 0),
                         $urandom_range(7, 0));
      if ($urandom_range(1, 0) == 1) begin
        do_write(addr_r, $urandom, 4'($urandom_range(15, 1)));
      end else begin
        do_read(addr_r);
      end
    end
    check_cmd_counts();
    report_test("random traffic");

    $display("closing count: %0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && total_errors() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
logic/cache_pkg.sv
logic/line_store.sv
logic/cmd_interval_timer.sv
logic/burst_ctrl_fsm.sv
logic/cache_top.sv
testbench/burst_ram_model.sv
testbench/cache_tb.sv

//--- Bender.yml
package:
  name: burst_cache

sources:
  - logic/cache_pkg.sv
  - logic/line_store.sv
  - logic/cmd_interval_timer.sv
  - logic/burst_ctrl_fsm.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - testbench/burst_ram_model.sv
      - testbench/cache_tb.sv
